/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_decode_top
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?=
PASS_MSG ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --assert --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) $(VFLAGS)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST) $(VFLAGS)

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
hdl/core_pkg.sv
hdl/decode_if.sv
hdl/instr_ingress.sv
hdl/decoder_2r.sv
hdl/decoder_3r.sv
hdl/decode_unit.sv
hdl/dispatch_egress.sv
hdl/decode_top.sv
testbench/decode_properties.sv
testbench/tb_decode_top.sv

/* hdl/core_pkg.sv */
package core_pkg;

    localparam int GPR_NUM = 32;
    localparam int GPR_ADDR_W = $clog2(GPR_NUM);

    localparam int ALU_OP_W = 8;
    localparam int ALU_SEL_W = 3;

    // queue depth doubles as the fetch side's starting credit
    localparam int INGRESS_DEPTH = 4;
    localparam int INGRESS_PTR_W = $clog2(INGRESS_DEPTH);
    localparam int INGRESS_CNT_W = $clog2(INGRESS_DEPTH + 1);
    localparam int EGRESS_CREDITS = 2;
    localparam int EGRESS_CNT_W = $clog2(EGRESS_CREDITS + 1);

    // 2r opcodes in bits 31 to 10
    localparam logic [21:0] OPC_TLBSRCH = 22'h1920a;
    localparam logic [21:0] OPC_TLBRD = 22'h1920b;
    localparam logic [21:0] OPC_TLBWR = 22'h1920c;
    localparam logic [21:0] OPC_TLBFILL = 22'h1920d;
    localparam logic [21:0] OPC_ERTN = 22'h1920e;
    localparam logic [21:0] OPC_RDCNTIDV = 22'h18;
    localparam logic [21:0] OPC_RDCNTVH = 22'h19;

    // 3r opcodes in bits 31 to 15
    localparam logic [16:0] OPC_ADDW = 17'h20;
    localparam logic [16:0] OPC_SUBW = 17'h22;
    localparam logic [16:0] OPC_SLT = 17'h24;
    localparam logic [16:0] OPC_SLTU = 17'h25;
    localparam logic [16:0] OPC_AND = 17'h29;
    localparam logic [16:0] OPC_OR = 17'h2a;
    localparam logic [16:0] OPC_XOR = 17'h2b;

    localparam logic [ALU_OP_W-1:0] OP_NOP = 8'd0;
    localparam logic [ALU_OP_W-1:0] OP_TLBSRCH = 8'd1;
    localparam logic [ALU_OP_W-1:0] OP_TLBRD = 8'd2;
    localparam logic [ALU_OP_W-1:0] OP_TLBWR = 8'd3;
    localparam logic [ALU_OP_W-1:0] OP_TLBFILL = 8'd4;
    localparam logic [ALU_OP_W-1:0] OP_ERTN = 8'd5;
    localparam logic [ALU_OP_W-1:0] OP_RDCNTID = 8'd6;
    localparam logic [ALU_OP_W-1:0] OP_RDCNTVL = 8'd7;
    localparam logic [ALU_OP_W-1:0] OP_RDCNTVH = 8'd8;
    localparam logic [ALU_OP_W-1:0] OP_ADD = 8'd9;
    localparam logic [ALU_OP_W-1:0] OP_SUB = 8'd10;
    localparam logic [ALU_OP_W-1:0] OP_SLT = 8'd11;
    localparam logic [ALU_OP_W-1:0] OP_SLTU = 8'd12;
    localparam logic [ALU_OP_W-1:0] OP_AND = 8'd13;
    localparam logic [ALU_OP_W-1:0] OP_OR = 8'd14;
    localparam logic [ALU_OP_W-1:0] OP_XOR = 8'd15;

    localparam logic [ALU_SEL_W-1:0] SEL_NONE = 3'd0;
    localparam logic [ALU_SEL_W-1:0] SEL_ARITH = 3'd1;
    localparam logic [ALU_SEL_W-1:0] SEL_LOGIC = 3'd2;
    localparam logic [ALU_SEL_W-1:0] SEL_CSR = 3'd3;

    typedef struct packed {
        logic [21:0] opcode;
        logic [GPR_ADDR_W-1:0] rj;
        logic [GPR_ADDR_W-1:0] rd;
    } r2_fmt_t;

    typedef struct packed {
        logic [16:0] opcode;
        logic [GPR_ADDR_W-1:0] rk;
        logic [GPR_ADDR_W-1:0] rj;
        logic [GPR_ADDR_W-1:0] rd;
    } r3_fmt_t;

    // same fetched word seen by both decoders
    typedef union packed {
        r2_fmt_t r2;
        r3_fmt_t r3;
    } instr_word_u;

endpackage

/* hdl/decode_if.sv */
interface decode_if;
    import core_pkg::*;

    logic valid;
    logic take;
    logic illegal;
    logic [ALU_OP_W-1:0] aluop;
    logic [ALU_SEL_W-1:0] alusel;
    // {rk, rj}
    logic [1:0] reg_read_valid;
    logic [2*GPR_ADDR_W-1:0] reg_read_addr;
    logic reg_write_valid;
    logic [GPR_ADDR_W-1:0] reg_write_addr;
    logic is_pri;
    logic kernel;
    logic not_commit;

    modport src (
        output valid, illegal, aluop, alusel, reg_read_valid, reg_read_addr,
        output reg_write_valid, reg_write_addr, is_pri, kernel, not_commit,
        input take
    );

    modport sink (
        input valid, illegal, aluop, alusel, reg_read_valid, reg_read_addr,
        input reg_write_valid, reg_write_addr, is_pri, kernel, not_commit,
        output take
    );

endinterface

/* hdl/decode_top.sv */
module decode_top (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic out_credit_i,
    output logic instr_credit_o,
    output logic out_valid_o,
    output logic out_illegal_o,
    output logic [core_pkg::ALU_OP_W-1:0] out_aluop_o,
    output logic [core_pkg::ALU_SEL_W-1:0] out_alusel_o,
    output logic [1:0] out_reg_read_valid_o,
    output logic [2*core_pkg::GPR_ADDR_W-1:0] out_reg_read_addr_o,
    output logic out_reg_write_valid_o,
    output logic [core_pkg::GPR_ADDR_W-1:0] out_reg_write_addr_o,
    output logic out_is_pri_o,
    output logic out_kernel_o,
    output logic out_not_commit_o
);

    logic [31:0] head_word;
    logic head_valid;
    logic head_pop;

    decode_if dec_bus ();

    instr_ingress u_ingress (
        .clk_i(clk_i),
        .arst_n_i(arst_n_i),
        .instr_valid_i(instr_valid_i),
        .instr_i(instr_i),
        .head_pop_i(head_pop),
        .head_word_o(head_word),
        .head_valid_o(head_valid),
        .instr_credit_o(instr_credit_o)
    );

    decode_unit u_decode (
        .clk_i(clk_i),
        .arst_n_i(arst_n_i),
        .head_word_i(head_word),
        .head_valid_i(head_valid),
        .head_pop_o(head_pop),
        .dec(dec_bus.src)
    );

    dispatch_egress u_egress (
        .clk_i(clk_i),
        .arst_n_i(arst_n_i),
        .out_credit_i(out_credit_i),
        .dec(dec_bus.sink),
        .out_valid_o(out_valid_o),
        .out_illegal_o(out_illegal_o),
        .out_aluop_o(out_aluop_o),
        .out_alusel_o(out_alusel_o),
        .out_reg_read_valid_o(out_reg_read_valid_o),
        .out_reg_read_addr_o(out_reg_read_addr_o),
        .out_reg_write_valid_o(out_reg_write_valid_o),
        .out_reg_write_addr_o(out_reg_write_addr_o),
        .out_is_pri_o(out_is_pri_o),
        .out_kernel_o(out_kernel_o),
        .out_not_commit_o(out_not_commit_o)
    );

endmodule

/* hdl/decode_unit.sv */
module decode_unit (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic [31:0] head_word_i,
    input  logic        head_valid_i,
    output logic        head_pop_o,
    decode_if.src       dec
);
    import core_pkg::*;

    instr_word_u word;
    logic m2, ill2, wv2, pri2, kern2, nc2;
    logic [ALU_OP_W-1:0] op2;
    logic [ALU_SEL_W-1:0] sel2;
    logic [GPR_ADDR_W-1:0] wa2;
    logic m3;
    logic [ALU_OP_W-1:0] op3;
    logic [ALU_SEL_W-1:0] sel3;
    logic [1:0] rv3;
    logic [2*GPR_ADDR_W-1:0] ra3;
    logic [GPR_ADDR_W-1:0] wa3;

    logic n_illegal, n_wv, n_pri, n_kern, n_nc;
    logic [ALU_OP_W-1:0] n_op;
    logic [ALU_SEL_W-1:0] n_sel;
    logic [1:0] n_rv;
    logic [2*GPR_ADDR_W-1:0] n_ra;
    logic [GPR_ADDR_W-1:0] n_wa;

    assign word = head_word_i;

    decoder_2r u_dec2r (
        .word_i(word), .match_o(m2), .illegal_o(ill2), .aluop_o(op2), .alusel_o(sel2),
        .reg_write_valid_o(wv2), .reg_write_addr_o(wa2), .is_pri_o(pri2),
        .kernel_o(kern2), .not_commit_o(nc2)
    );

    decoder_3r u_dec3r (
        .word_i(word), .match_o(m3), .aluop_o(op3), .alusel_o(sel3),
        .reg_read_valid_o(rv3), .reg_read_addr_o(ra3), .reg_write_addr_o(wa3)
    );

    // 2r wins over 3r and anything unmatched goes out illegal and zeroed
    always_comb begin
        n_illegal = 1'b0;
        n_op = OP_NOP;
        n_sel = SEL_NONE;
        n_rv = 2'b00;
        n_ra = '0;
        n_wv = 1'b0;
        n_wa = '0;
        n_pri = 1'b0;
        n_kern = 1'b0;
        n_nc = 1'b0;
        if (m2 && ill2) begin
            n_illegal = 1'b1;
        end else if (m2) begin
            n_op = op2;
            n_sel = sel2;
            n_wv = wv2;
            n_wa = wa2;
            n_pri = pri2;
            n_kern = kern2;
            n_nc = nc2;
        end else if (m3) begin
            n_op = op3;
            n_sel = sel3;
            n_rv = rv3;
            n_ra = ra3;
            n_wv = 1'b1;
            n_wa = wa3;
        end else begin
            n_illegal = 1'b1;
        end
    end

    // refill when empty or draining this cycle
    assign head_pop_o = head_valid_i && (!dec.valid || dec.take);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec.valid <= 1'b0;
        end else if (head_pop_o) begin
            dec.valid <= 1'b1;
        end else if (dec.take) begin
            dec.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (head_pop_o) begin
            dec.illegal <= n_illegal;
            dec.aluop <= n_op;
            dec.alusel <= n_sel;
            dec.reg_read_valid <= n_rv;
            dec.reg_read_addr <= n_ra;
            dec.reg_write_valid <= n_wv;
            dec.reg_write_addr <= n_wa;
            dec.is_pri <= n_pri;
            dec.kernel <= n_kern;
            dec.not_commit <= n_nc;
        end
    end

endmodule

/* hdl/decoder_2r.sv */
module decoder_2r (
    input  core_pkg::instr_word_u word_i,
    output logic match_o,
    output logic illegal_o,
    output logic [core_pkg::ALU_OP_W-1:0] aluop_o,
    output logic [core_pkg::ALU_SEL_W-1:0] alusel_o,
    output logic reg_write_valid_o,
    output logic [core_pkg::GPR_ADDR_W-1:0] reg_write_addr_o,
    output logic is_pri_o,
    output logic kernel_o,
    output logic not_commit_o
);
    import core_pkg::*;

    always_comb begin
        match_o = 1'b1;
        illegal_o = 1'b0;
        aluop_o = OP_NOP;
        alusel_o = SEL_NONE;
        reg_write_valid_o = 1'b0;
        reg_write_addr_o = '0;
        is_pri_o = 1'b0;
        kernel_o = 1'b0;
        not_commit_o = 1'b0;
        case (word_i.r2.opcode)
            OPC_TLBSRCH: begin
                aluop_o = OP_TLBSRCH;
                is_pri_o = 1'b1;
                kernel_o = 1'b1;
            end
            OPC_TLBRD: begin
                aluop_o = OP_TLBRD;
                is_pri_o = 1'b1;
                kernel_o = 1'b1;
            end
            OPC_TLBWR: begin
                aluop_o = OP_TLBWR;
                is_pri_o = 1'b1;
                kernel_o = 1'b1;
            end
            OPC_TLBFILL: begin
                aluop_o = OP_TLBFILL;
                is_pri_o = 1'b1;
                kernel_o = 1'b1;
            end
            // ertn leaves without a normal commit
            OPC_ERTN: begin
                aluop_o = OP_ERTN;
                is_pri_o = 1'b1;
                kernel_o = 1'b1;
                not_commit_o = 1'b1;
            end
            OPC_RDCNTIDV: begin
                alusel_o = SEL_CSR;
                is_pri_o = 1'b1;
                // rd zero selects the counter id into rj
                if (word_i.r2.rd == '0) begin
                    reg_write_valid_o = 1'b1;
                    reg_write_addr_o = word_i.r2.rj;
                    aluop_o = OP_RDCNTID;
                end else if (word_i.r2.rj == '0) begin
                    reg_write_valid_o = 1'b1;
                    reg_write_addr_o = word_i.r2.rd;
                    aluop_o = OP_RDCNTVL;
                end else begin
                    illegal_o = 1'b1;
                end
            end
            OPC_RDCNTVH: begin
                aluop_o = OP_RDCNTVH;
                alusel_o = SEL_CSR;
                is_pri_o = 1'b1;
                reg_write_valid_o = 1'b1;
                reg_write_addr_o = word_i.r2.rd;
            end
            default: begin
                match_o = 1'b0;
            end
        endcase
    end

endmodule

/* hdl/decoder_3r.sv */
module decoder_3r (
    input  core_pkg::instr_word_u word_i,
    output logic match_o,
    output logic [core_pkg::ALU_OP_W-1:0] aluop_o,
    output logic [core_pkg::ALU_SEL_W-1:0] alusel_o,
    output logic [1:0] reg_read_valid_o,
    output logic [2*core_pkg::GPR_ADDR_W-1:0] reg_read_addr_o,
    output logic [core_pkg::GPR_ADDR_W-1:0] reg_write_addr_o
);
    import core_pkg::*;

    always_comb begin
        match_o = 1'b1;
        aluop_o = OP_NOP;
        alusel_o = SEL_NONE;
        case (word_i.r3.opcode)
            OPC_ADDW: begin
                aluop_o = OP_ADD;
                alusel_o = SEL_ARITH;
            end
            OPC_SUBW: begin
                aluop_o = OP_SUB;
                alusel_o = SEL_ARITH;
            end
            OPC_SLT: begin
                aluop_o = OP_SLT;
                alusel_o = SEL_ARITH;
            end
            OPC_SLTU: begin
                aluop_o = OP_SLTU;
                alusel_o = SEL_ARITH;
            end
            OPC_AND: begin
                aluop_o = OP_AND;
                alusel_o = SEL_LOGIC;
            end
            OPC_OR: begin
                aluop_o = OP_OR;
                alusel_o = SEL_LOGIC;
            end
            OPC_XOR: begin
                aluop_o = OP_XOR;
                alusel_o = SEL_LOGIC;
            end
            default: begin
                match_o = 1'b0;
            end
        endcase
    end

    // every 3r op reads rk and rj and writes rd
    assign reg_read_valid_o = match_o ? 2'b11 : 2'b00;
    assign reg_read_addr_o = match_o ? {word_i.r3.rk, word_i.r3.rj} : '0;
    assign reg_write_addr_o = match_o ? word_i.r3.rd : '0;

endmodule

/* hdl/dispatch_egress.sv */
module dispatch_egress (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic out_credit_i,
    decode_if.sink dec,
    output logic out_valid_o,
    output logic out_illegal_o,
    output logic [core_pkg::ALU_OP_W-1:0] out_aluop_o,
    output logic [core_pkg::ALU_SEL_W-1:0] out_alusel_o,
    output logic [1:0] out_reg_read_valid_o,
    output logic [2*core_pkg::GPR_ADDR_W-1:0] out_reg_read_addr_o,
    output logic out_reg_write_valid_o,
    output logic [core_pkg::GPR_ADDR_W-1:0] out_reg_write_addr_o,
    output logic out_is_pri_o,
    output logic out_kernel_o,
    output logic out_not_commit_o
);
    import core_pkg::*;

    logic [EGRESS_CNT_W-1:0] credit_cnt;
    logic xfer;

    assign dec.take = dec.valid && (credit_cnt != '0);
    assign xfer = dec.valid && dec.take;

    // take and a returned credit may land in the same cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_cnt <= EGRESS_CNT_W'(EGRESS_CREDITS);
            out_valid_o <= 1'b0;
        end else begin
            credit_cnt <= credit_cnt - EGRESS_CNT_W'(xfer) + EGRESS_CNT_W'(out_credit_i);
            out_valid_o <= xfer;
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer) begin
            out_illegal_o <= dec.illegal;
            out_aluop_o <= dec.aluop;
            out_alusel_o <= dec.alusel;
            out_reg_read_valid_o <= dec.reg_read_valid;
            out_reg_read_addr_o <= dec.reg_read_addr;
            out_reg_write_valid_o <= dec.reg_write_valid;
            out_reg_write_addr_o <= dec.reg_write_addr;
            out_is_pri_o <= dec.is_pri;
            out_kernel_o <= dec.kernel;
            out_not_commit_o <= dec.not_commit;
        end
    end

endmodule

/* hdl/instr_ingress.sv */
module instr_ingress (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic        head_pop_i,
    output logic [31:0] head_word_o,
    output logic        head_valid_o,
    output logic        instr_credit_o
);
    import core_pkg::*;

    logic [31:0] mem [INGRESS_DEPTH];
    logic [INGRESS_PTR_W-1:0] wr_ptr;
    logic [INGRESS_PTR_W-1:0] rd_ptr;
    logic [INGRESS_CNT_W-1:0] count;
    logic full;
    logic push;
    logic pop;

    assign full = (count == INGRESS_CNT_W'(INGRESS_DEPTH));
    assign push = instr_valid_i && !full;
    assign pop = head_pop_i && head_valid_o;

    assign head_valid_o = (count != '0);
    assign head_word_o = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= instr_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + INGRESS_PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + INGRESS_PTR_W'(1);
            end
            count <= count + INGRESS_CNT_W'(push) - INGRESS_CNT_W'(pop);
        end
    end

    // one credit back to fetch per released slot
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            instr_credit_o <= 1'b0;
        end else begin
            instr_credit_o <= pop;
        end
    end

endmodule

/* testbench/decode_properties.sv */
module decode_properties (
    input logic clk_i,
    input logic arst_n_i,
    input logic [core_pkg::EGRESS_CNT_W-1:0] credit_cnt_i,
    input logic out_valid_i,
    input logic instr_valid_i,
    input logic full_i
);
    import core_pkg::*;

    // dispatch never hands back more than it was given
    credit_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        credit_cnt_i <= EGRESS_CNT_W'(EGRESS_CREDITS))
        else $error("egress credit count above its initial value");

    // each operation out spent a credit held one cycle earlier
    out_needs_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_valid_i |-> $past(credit_cnt_i) != '0)
        else $error("operation sent while egress held no credit");

    no_write_when_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_valid_i |-> !full_i)
        else $error("fetch wrote into a full ingress queue");

endmodule

/* testbench/tb_decode_top.sv */
module tb_decode_top;
    import core_pkg::*;

    typedef struct packed {
        logic illegal;
        logic [ALU_OP_W-1:0] aluop;
        logic [ALU_SEL_W-1:0] alusel;
        logic [1:0] rd_valid;
        logic [2*GPR_ADDR_W-1:0] rd_addr;
        logic wr_valid;
        logic [GPR_ADDR_W-1:0] wr_addr;
        logic is_pri;
        logic kernel;
        logic not_commit;
    } result_t;

    localparam int SEND_LIMIT = 5000;
    localparam int DRAIN_LIMIT = 2000;

    logic clk_i;
    logic arst_n_i;
    logic instr_valid_i;
    logic [31:0] instr_i;
    logic out_credit_i;
    logic instr_credit_o;
    logic out_valid_o;
    logic out_illegal_o;
    logic [ALU_OP_W-1:0] out_aluop_o;
    logic [ALU_SEL_W-1:0] out_alusel_o;
    logic [1:0] out_reg_read_valid_o;
    logic [2*GPR_ADDR_W-1:0] out_reg_read_addr_o;
    logic out_reg_write_valid_o;
    logic [GPR_ADDR_W-1:0] out_reg_write_addr_o;
    logic out_is_pri_o;
    logic out_kernel_o;
    logic out_not_commit_o;

    result_t exp_q[$];
    integer seed;
    int fetch_credit;
    int pending_ret;
    int credit_pulses;
    int received;
    int errors;
    int tests_run;
    int send_pct;
    int ret_pct;
    bit timed_out;

    logic [21:0] opc_priv [5] = '{OPC_TLBSRCH, OPC_TLBRD, OPC_TLBWR, OPC_TLBFILL, OPC_ERTN};
    logic [16:0] opc_int [7] = '{OPC_ADDW, OPC_SUBW, OPC_SLT, OPC_SLTU, OPC_AND, OPC_OR, OPC_XOR};

    decode_top u_decode_top (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .instr_valid_i(instr_valid_i),
        .instr_i(instr_i), .out_credit_i(out_credit_i), .instr_credit_o(instr_credit_o),
        .out_valid_o(out_valid_o), .out_illegal_o(out_illegal_o), .out_aluop_o(out_aluop_o),
        .out_alusel_o(out_alusel_o), .out_reg_read_valid_o(out_reg_read_valid_o),
        .out_reg_read_addr_o(out_reg_read_addr_o),
        .out_reg_write_valid_o(out_reg_write_valid_o),
        .out_reg_write_addr_o(out_reg_write_addr_o), .out_is_pri_o(out_is_pri_o),
        .out_kernel_o(out_kernel_o), .out_not_commit_o(out_not_commit_o)
    );

    bind dispatch_egress decode_properties u_egress_props (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .credit_cnt_i(credit_cnt),
        .out_valid_i(out_valid_o), .instr_valid_i(1'b0), .full_i(1'b0)
    );

    bind instr_ingress decode_properties u_ingress_props (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .credit_cnt_i('0),
        .out_valid_i(1'b0), .instr_valid_i(instr_valid_i), .full_i(full)
    );

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic bit roll_percent(input int pct);
        int r;
        r = $random(seed);
        r = r & 32'h7fff_ffff;
        return (r % 100) < pct;
    endfunction

    // kind 1 priv, 2 counter reads, 3 integer ops, 4 raw random, 5 any of these
    function automatic logic [31:0] make_word(input int kind);
        logic [31:0] w;
        logic [4:0] rj;
        logic [4:0] rd;
        logic [2:0] idx;
        int pick;
        w = rand_word();
        rj = w[9:5];
        rd = w[4:0];
        pick = kind;
        if (kind == 5) begin
            pick = 1 + int'(rand_word() % 32'd4);
        end
        case (pick)
            1: begin
                idx = 3'(rand_word() % 32'd5);
                w = {opc_priv[idx], rj, rd};
            end
            2: begin
                // half the time clear each field so every variant shows up
                if (w[20]) rd = '0;
                if (w[21]) rj = '0;
                w = {w[22] ? OPC_RDCNTVH : OPC_RDCNTIDV, rj, rd};
            end
            3: begin
                idx = 3'(rand_word() % 32'd7);
                w = {opc_int[idx], w[14:0]};
            end
            default: begin
            end
        endcase
        return w;
    endfunction

    function automatic result_t predict(input logic [31:0] w);
        result_t r;
        logic [21:0] op2;
        logic [16:0] op3;
        logic [4:0] rj;
        logic [4:0] rd;
        r = '0;
        op2 = w[31:10];
        op3 = w[31:15];
        rj = w[9:5];
        rd = w[4:0];
        if (op2 >= OPC_TLBSRCH && op2 <= OPC_ERTN) begin
            // tlb ops and ertn are consecutive in both opcode and aluop order
            r.aluop = OP_TLBSRCH + 8'(op2 - OPC_TLBSRCH);
            r.is_pri = 1'b1;
            r.kernel = 1'b1;
            r.not_commit = (op2 == OPC_ERTN);
        end else if (op2 == OPC_RDCNTVH ||
                     (op2 == OPC_RDCNTIDV && (rd == 5'd0 || rj == 5'd0))) begin
            r.alusel = SEL_CSR;
            r.is_pri = 1'b1;
            r.wr_valid = 1'b1;
            if (op2 == OPC_RDCNTVH) begin
                r.aluop = OP_RDCNTVH;
                r.wr_addr = rd;
            end else begin
                r.aluop = (rd == 5'd0) ? OP_RDCNTID : OP_RDCNTVL;
                r.wr_addr = (rd == 5'd0) ? rj : rd;
            end
        end else if (op2 == OPC_RDCNTIDV) begin
            r.illegal = 1'b1;
        end else begin
            r.rd_valid = 2'b11;
            r.rd_addr = w[14:5];
            r.wr_valid = 1'b1;
            r.wr_addr = rd;
            r.alusel = (op3 >= OPC_AND) ? SEL_LOGIC : SEL_ARITH;
            case (op3)
                OPC_ADDW: r.aluop = OP_ADD;
                OPC_SUBW: r.aluop = OP_SUB;
                OPC_SLT: r.aluop = OP_SLT;
                OPC_SLTU: r.aluop = OP_SLTU;
                OPC_AND: r.aluop = OP_AND;
                OPC_OR: r.aluop = OP_OR;
                OPC_XOR: r.aluop = OP_XOR;
                default: begin
                    r = '0;
                    r.illegal = 1'b1;
                end
            endcase
        end
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
            errors++;
        end
    endtask

    // fetch words and dispatch credits driven on one rising edge
    task automatic drive_cycle(input int kind, input bit may_send, inout int sent);
        logic [31:0] w;
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        out_credit_i <= 1'b0;
        if (pending_ret > 0 && roll_percent(ret_pct)) begin
            out_credit_i <= 1'b1;
            pending_ret--;
        end
        if (may_send && fetch_credit > 0 && roll_percent(send_pct)) begin
            w = make_word(kind);
            instr_valid_i <= 1'b1;
            instr_i <= w;
            exp_q.push_back(predict(w));
            fetch_credit--;
            sent++;
        end
    endtask

    task automatic run_test(input int kind, input string name, input int words,
                            input int base_pct, input bit bursty);
        int sent;
        int cycles;
        int err_before;
        int pulses_before;
        int recv_before;
        sent = 0;
        cycles = 0;
        err_before = errors;
        pulses_before = credit_pulses;
        recv_before = received;
        send_pct = bursty ? 100 : 60;
        ret_pct = base_pct;
        tests_run++;
        while (sent < words && !timed_out) begin
            // credits come back in long droughts then floods
            if (bursty) begin
                ret_pct = ((cycles / 40) % 2 == 0) ? 5 : 90;
            end
            drive_cycle(kind, 1'b1, sent);
            cycles++;
            if (cycles > SEND_LIMIT) begin
                $display("timeout: test %0d could not send all of its words", kind);
                timed_out = 1'b1;
            end
        end
        cycles = 0;
        ret_pct = 70;
        // the last fetch credit returns before the last operation leaves
        while (exp_q.size() != 0 && !timed_out) begin
            drive_cycle(kind, 1'b0, sent);
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                $display("timeout: test %0d did not drain its outstanding words", kind);
                timed_out = 1'b1;
            end
        end
        if (received - recv_before != sent) begin
            $display("test %0d got %0d operations for %0d words", kind,
                     received - recv_before, sent);
            errors++;
        end
        if (credit_pulses - pulses_before != sent) begin
            $display("test %0d saw %0d fetch credits for %0d words", kind,
                     credit_pulses - pulses_before, sent);
            errors++;
        end
        $display("test %0d %s: %0d words, %0d errors", kind, name, sent, errors - err_before);
    endtask

    always @(negedge clk_i) begin : monitor
        result_t want;
        if (arst_n_i) begin
            if (instr_credit_o) begin
                fetch_credit++;
                credit_pulses++;
            end
            if (out_valid_o) begin
                received++;
                pending_ret++;
                if (exp_q.size() == 0) begin
                    $display("operation came out with no word outstanding");
                    errors++;
                end else begin
                    want = exp_q.pop_front();
                    check_field("out_illegal_o", 32'(want.illegal), 32'(out_illegal_o));
                    check_field("out_aluop_o", 32'(want.aluop), 32'(out_aluop_o));
                    check_field("out_alusel_o", 32'(want.alusel), 32'(out_alusel_o));
                    check_field("out_reg_read_valid_o", 32'(want.rd_valid),
                                32'(out_reg_read_valid_o));
                    check_field("out_reg_read_addr_o", 32'(want.rd_addr),
                                32'(out_reg_read_addr_o));
                    check_field("out_reg_write_valid_o", 32'(want.wr_valid),
                                32'(out_reg_write_valid_o));
                    check_field("out_reg_write_addr_o", 32'(want.wr_addr),
                                32'(out_reg_write_addr_o));
                    check_field("out_is_pri_o", 32'(want.is_pri), 32'(out_is_pri_o));
                    check_field("out_kernel_o", 32'(want.kernel), 32'(out_kernel_o));
                    check_field("out_not_commit_o", 32'(want.not_commit), 32'(out_not_commit_o));
                end
            end
        end
    end

    initial begin
        seed = 30;
        clk_i = 1'b0;
        arst_n_i = 1'b0;
        instr_valid_i = 1'b0;
        instr_i = '0;
        out_credit_i = 1'b0;
        fetch_credit = INGRESS_DEPTH;
        pending_ret = 0;
        credit_pulses = 0;
        received = 0;
        errors = 0;
        tests_run = 0;
        send_pct = 0;
        ret_pct = 0;
        timed_out = 1'b0;
        repeat (10) @(posedge clk_i);
        arst_n_i <= 1'b1;
        run_test(1, "tlb and ertn", 40, 80, 1'b0);
        run_test(2, "counter reads", 60, 80, 1'b0);
        run_test(3, "3r integer ops", 60, 80, 1'b0);
        run_test(4, "random words", 60, 80, 1'b0);
        run_test(5, "mixed under bursty credits", 200, 10, 1'b1);
        $display("%0d tests, %0d operations checked, %0d errors", tests_run, received, errors);
        if (errors == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
